/* logic/clk_cfg.svh */
`ifndef CLK_CFG_SVH
`define CLK_CFG_SVH

// clk rate as a multiple of 10.738635 MHz
`define VDP_MULT 2

// clk rate over 3 MHz, rounded
`define CPU_MULT 7

// clk rate over 160 kHz, must fit the 10-bit tick counter
`define VSP_MULT 134

// Overlay pixel strobe, needs an even VDP_MULT
`define OVERLAY_EN 1

`define GROM_DIV 8         // SGC strobes per GROM strobe

`define RESET_TICKS 16     // 3 MHz ticks that reset_out stays high

`endif

/* logic/clk_pkg.sv */
package clk_pkg;

   // Reset sequencer states
   typedef enum logic [1:0] {
      rst_hold,    // External reset active
      rst_count,   // Counting 3 MHz ticks after release
      rst_run      // System out of reset
   } rst_state_t;

   // Shared counter width for the VSP divider and the reset counter
   typedef logic [9:0] tick_cnt_t;

endpackage

/* logic/clk_en_if.sv */
`timescale 1ns/1ns

interface clk_en_if;

   logic vdp;              // VDP pixel strobe
   logic vdp_next;         // One cycle ahead of vdp
   logic vga;              // Scan-doubler pixel strobe
   logic sgc;              // Sound/game chip strobe
   logic sgc_next;         // One cycle ahead of sgc
   logic tick_3mhz;        // Peripheral tick
   logic tick_3mhz_next;   // One cycle ahead of tick_3mhz

   modport src (
      output vdp,
      output vdp_next,
      output vga,
      output sgc,
      output sgc_next,
      output tick_3mhz,
      output tick_3mhz_next
   );

   modport dst (
      input vdp,
      input vdp_next,
      input vga,
      input sgc,
      input sgc_next,
      input tick_3mhz,
      input tick_3mhz_next
   );

endinterface

/* logic/ring_dividers.sv */
`timescale 1ns/1ns
`include "clk_cfg.svh"

module ring_dividers (
   input  logic     clk,
   input  logic     ext_reset_in,
   clk_en_if.src    en,
   output logic     overlay_clk_en
);

   // Ring lengths in clk cycles
   localparam int vdp_n  = 2 * `VDP_MULT;
   localparam int vga_n  = `VDP_MULT;
   localparam int sgc_n  = 3 * `VDP_MULT;
   localparam int tick_n = `CPU_MULT;

   // Single one in position 1 after reset
   localparam logic [1:vdp_n]  vdp_init  = vdp_n'(1) << (vdp_n - 1);
   localparam logic [1:vga_n]  vga_init  = vga_n'(1) << (vga_n - 1);
   localparam logic [1:sgc_n]  sgc_init  = sgc_n'(1) << (sgc_n - 1);
   localparam logic [1:tick_n] tick_init = tick_n'(1) << (tick_n - 1);

   logic [1:vdp_n]  vdp_ring;
   logic [1:vga_n]  vga_ring;
   logic [1:sgc_n]  sgc_ring;
   logic [1:tick_n] tick_ring;

   always_ff @(posedge clk) begin
      if (ext_reset_in) begin
         vdp_ring  <= vdp_init;
         vga_ring  <= vga_init;
         sgc_ring  <= sgc_init;
         tick_ring <= tick_init;
      end else begin
         // Rotate toward bit 1, bit 1 wraps to the far end
         vdp_ring  <= (vdp_ring << 1) | (vdp_ring >> (vdp_n - 1));
         vga_ring  <= (vga_ring << 1) | (vga_ring >> (vga_n - 1));
         sgc_ring  <= (sgc_ring << 1) | (sgc_ring >> (sgc_n - 1));
         tick_ring <= (tick_ring << 1) | (tick_ring >> (tick_n - 1));
      end
   end

   assign en.vdp            = vdp_ring[1];
   assign en.vdp_next       = vdp_ring[2];     // Bit 2 reaches bit 1 next cycle
   assign en.vga            = vga_ring[1];
   assign en.sgc            = sgc_ring[1];
   assign en.sgc_next       = sgc_ring[2];
   assign en.tick_3mhz      = tick_ring[1];
   assign en.tick_3mhz_next = tick_ring[2];

   generate
      if (`OVERLAY_EN != 0) begin : g_overlay
         if ((`VDP_MULT % 2) != 0) begin : g_bad_mult
            $fatal(1, "Overlay strobe needs an even VDP_MULT");
         end

         localparam int ovl_n = `VDP_MULT / 2;
         localparam logic [1:ovl_n] ovl_init = ovl_n'(1) << (ovl_n - 1);

         logic [1:ovl_n] ovl_ring;

         always_ff @(posedge clk) begin
            if (ext_reset_in) begin
               ovl_ring <= ovl_init;
            end else begin
               ovl_ring <= (ovl_ring << 1) | (ovl_ring >> (ovl_n - 1));
            end
         end

         assign overlay_clk_en = ovl_ring[1];
      end else begin : g_no_overlay
         assign overlay_clk_en = 1'b0;          // Overlay not built
      end
   endgenerate

endmodule

/* logic/derived_rates.sv */
`timescale 1ns/1ns
`include "clk_cfg.svh"

module derived_rates (
   input  logic     clk,
   input  logic     ext_reset_in,
   input  logic     cpu_turbo,
   clk_en_if.dst    en,
   output logic     cpu_clk_en,
   output logic     grom_clk_en,
   output logic     vsp_clk_en
);

   localparam logic [2:0] grom_last = 3'(`GROM_DIV - 1);
   localparam clk_pkg::tick_cnt_t vsp_last = clk_pkg::tick_cnt_t'(`VSP_MULT - 1);

   logic [2:0]         grom_cnt;   // Counts sgc_next strobes
   clk_pkg::tick_cnt_t vsp_cnt;    // Free-running VSP divider

   // CPU and GROM enables, turbo forces both high
   always_ff @(posedge clk) begin
      if (ext_reset_in) begin
         cpu_clk_en  <= 1'b1;
         grom_clk_en <= 1'b1;
         grom_cnt    <= 3'd0;
      end else begin
         if (cpu_turbo) begin
            cpu_clk_en  <= 1'b1;
            grom_clk_en <= 1'b1;
         end else begin
            cpu_clk_en  <= en.tick_3mhz_next;      // Lands on tick_3mhz
            grom_clk_en <= en.sgc_next && (grom_cnt == grom_last);
         end
         if (en.sgc_next) begin
            grom_cnt <= grom_cnt + 3'd1;           // Keeps counting in turbo
         end
      end
   end

   // VSP strobe, one pulse per VSP_MULT cycles
   always_ff @(posedge clk) begin
      if (ext_reset_in) begin
         vsp_clk_en <= 1'b1;
         vsp_cnt    <= '0;
      end else begin
         if (vsp_cnt == vsp_last) begin
            vsp_clk_en <= 1'b1;
            vsp_cnt    <= '0;
         end else begin
            vsp_clk_en <= 1'b0;
            vsp_cnt    <= vsp_cnt + 1'b1;
         end
      end
   end

endmodule

/* logic/reset_sequencer.sv */
`timescale 1ns/1ns
`include "clk_cfg.svh"

module reset_sequencer (
   input  logic     clk,
   input  logic     ext_reset_in,
   clk_en_if.dst    en,
   output logic     reset_out
);

   localparam clk_pkg::tick_cnt_t last_tick = clk_pkg::tick_cnt_t'(`RESET_TICKS - 1);

   clk_pkg::rst_state_t state;
   clk_pkg::tick_cnt_t  tick_cnt;   // 3 MHz ticks seen since release

   always_ff @(posedge clk) begin
      if (ext_reset_in) begin
         state    <= clk_pkg::rst_hold;
         tick_cnt <= '0;
      end else begin
         case (state)
            clk_pkg::rst_hold, clk_pkg::rst_count: begin
               // The first tick after release lands here already
               if (en.tick_3mhz && (tick_cnt == last_tick)) begin
                  state <= clk_pkg::rst_run;
               end else begin
                  state <= clk_pkg::rst_count;
               end
               if (en.tick_3mhz) begin
                  tick_cnt <= tick_cnt + 1'b1;
               end
            end
            clk_pkg::rst_run: begin
               state <= clk_pkg::rst_run;        // Stays until next ext reset
            end
            default: begin
               state    <= clk_pkg::rst_hold;
               tick_cnt <= '0;
            end
         endcase
      end
   end

   assign reset_out = (state != clk_pkg::rst_run);

endmodule

/* logic/clk_enables_top.sv */
`timescale 1ns/1ns

module clk_enables_top (
   input  logic clk,               // Multiple of 10.738635 MHz
   input  logic ext_reset_in,
   input  logic cpu_turbo,
   output logic reset_out,
   output logic vdp_clk_en,        // VDP pixel clock, 5.37 MHz
   output logic vdp_clk_en_next,
   output logic vga_clk_en,        // Scan-doubler pixel clock, 10.74 MHz
   output logic overlay_clk_en,    // Overlay pixel clock, 21.48 MHz
   output logic sgc_clk_en,        // SGC clock, 3.58 MHz
   output logic clk_3mhz_en,       // Peripheral tick
   output logic cpu_clk_en,
   output logic grom_clk_en,       // GROM clock, 447 kHz
   output logic vsp_clk_en         // Speech clock, 160 kHz
);

   clk_en_if ring_bus ();

   ring_dividers u_ring_dividers (
      .clk            (clk),
      .ext_reset_in   (ext_reset_in),
      .en             (ring_bus.src),
      .overlay_clk_en (overlay_clk_en)
   );

   derived_rates u_derived_rates (
      .clk          (clk),
      .ext_reset_in (ext_reset_in),
      .cpu_turbo    (cpu_turbo),
      .en           (ring_bus.dst),
      .cpu_clk_en   (cpu_clk_en),
      .grom_clk_en  (grom_clk_en),
      .vsp_clk_en   (vsp_clk_en)
   );

   reset_sequencer u_reset_sequencer (
      .clk          (clk),
      .ext_reset_in (ext_reset_in),
      .en           (ring_bus.dst),
      .reset_out    (reset_out)
   );

   // Base strobes go straight out
   assign vdp_clk_en      = ring_bus.vdp;
   assign vdp_clk_en_next = ring_bus.vdp_next;
   assign vga_clk_en      = ring_bus.vga;
   assign sgc_clk_en      = ring_bus.sgc;
   assign clk_3mhz_en     = ring_bus.tick_3mhz;

endmodule

/* bench/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic check_bit(input logic got, input logic exp, input string what);
   if (got !== exp) begin
      fail_run($sformatf("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp));
   end
endtask

task automatic check_count(input clk_pkg::tick_cnt_t got, input clk_pkg::tick_cnt_t exp,
                           input string what);
   if (got !== exp) begin
      fail_run($sformatf("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
   end
endtask

task automatic check_state(input clk_pkg::rst_state_t got, input clk_pkg::rst_state_t exp,
                           input string what);
   if (got !== exp) begin
      fail_run($sformatf("FAILED at %0t ns: %s is %s, expected %s", $time, what,
                         got.name(), exp.name()));
   end
endtask

// Counts one strobe
task automatic tally(inout clk_pkg::tick_cnt_t n, input logic s);
   if (s) begin
      n++;
   end
endtask

// A strobe with a period above one never repeats in the next cycle
task automatic no_adjacent(input logic prev, input logic now, input int period,
                           input string what);
   if (period > 1) begin
      check_bit(prev & now, 1'b0, {what, " high in two adjacent cycles"});
   end
endtask

// Galois LFSR, right shift, taps 32/22/2/1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
   return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

function automatic logic [31:0] rand_bits(input int n);
   logic [31:0] v;
   int          i;
   v = '0;
   for (i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);        // One step per bit
      v    = {v[30:0], lfsr[0]};
   end
   return v;
endfunction

`endif

/* bench/tb_clk_enables.sv */
`timescale 1ns/1ns
`include "clk_cfg.svh"

module tb_clk_enables;

   localparam int base_win       = 840;                       // Multiple of every ring length
   localparam int ovl_period     = (`VDP_MULT / 2 > 0) ? `VDP_MULT / 2 : 1;
   localparam int reset_win      = `RESET_TICKS * `CPU_MULT + `VSP_MULT;
   localparam int turbo_runs     = 20;
   localparam int turbo_max      = 8 + 31;                    // Longest random run
   localparam int vsp_win        = 4 * `VSP_MULT;
   localparam int test_cycles    = 2 * (reset_win + 4) + base_win
                                   + turbo_runs * turbo_max + vsp_win;
   localparam int timeout_cycles = test_cycles + test_cycles / 10;

   logic clk = 1'b0;
   logic ext_reset_in;
   logic cpu_turbo;
   logic reset_out;
   logic vdp_clk_en, vdp_clk_en_next, vga_clk_en, overlay_clk_en;
   logic sgc_clk_en, clk_3mhz_en, cpu_clk_en, grom_clk_en, vsp_clk_en;

   int          cycle_count = 0;
   int          rel_cyc     = 0;       // Cycles since the last reset release
   int          grom_seen   = 0;       // SGC strobes after the origin, mod GROM_DIV
   logic        grom_due    = 1'b0;    // GROM strobe expected in this cycle without turbo
   logic        turbo_now   = 1'b0;
   logic        turbo_last  = 1'b0;    // Turbo as the DUT sampled it for this cycle
   logic [31:0] lfsr        = 32'h210e_b0eb;

   always #2 clk = ~clk;               // 4 ns period

   clk_enables_top dut0 (
      .clk             (clk),
      .ext_reset_in    (ext_reset_in),
      .cpu_turbo       (cpu_turbo),
      .reset_out       (reset_out),
      .vdp_clk_en      (vdp_clk_en),
      .vdp_clk_en_next (vdp_clk_en_next),
      .vga_clk_en      (vga_clk_en),
      .overlay_clk_en  (overlay_clk_en),
      .sgc_clk_en      (sgc_clk_en),
      .clk_3mhz_en     (clk_3mhz_en),
      .cpu_clk_en      (cpu_clk_en),
      .grom_clk_en     (grom_clk_en),
      .vsp_clk_en      (vsp_clk_en)
   );

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("FAIL: see errors above");
      $fatal(1, "Stopped at the first error");
   endtask

   `include "tb_checks.svh"

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_cycles) begin
         fail_run($sformatf("Timeout: tests still running after %0d cycles", cycle_count));
      end
   end

   // Advances to the middle of the next cycle and updates the reference model
   task automatic next_cycle();
      turbo_last = turbo_now;
      @(negedge clk);
      turbo_now = cpu_turbo;
      rel_cyc++;
      grom_due = sgc_clk_en && (grom_seen == `GROM_DIV - 1);
      if (sgc_clk_en && rel_cyc > 0) begin
         grom_seen = (grom_seen + 1) % `GROM_DIV;    // Origin strobe not counted
      end
   endtask

   task automatic pulse_reset();
      @(posedge clk);
      ext_reset_in <= 1'b1;
      next_cycle();
      repeat (2) begin
         next_cycle();
         check_bit(reset_out, 1'b1, "reset_out while ext_reset_in is high");
      end
      @(posedge clk);
      ext_reset_in <= 1'b0;
      rel_cyc   = -1;                  // Next cycle is the phase origin
      grom_seen = 0;
   endtask

   task automatic reset_length();
      clk_pkg::tick_cnt_t  seen;
      clk_pkg::rst_state_t want;
      clk_pkg::rst_state_t got;
      int                  c;
      seen = '0;
      pulse_reset();
      for (c = 0; c < reset_win; c++) begin
         next_cycle();
         if (c == 0) begin
            check_bit(vdp_clk_en & vga_clk_en & sgc_clk_en & clk_3mhz_en, 1'b1,
                      "ring strobes in the first cycle after release");
            check_bit(overlay_clk_en, `OVERLAY_EN != 0, "overlay_clk_en after release");
         end
         got  = reset_out ? ((c == 0) ? clk_pkg::rst_hold : clk_pkg::rst_count)
                          : clk_pkg::rst_run;
         want = (seen >= clk_pkg::tick_cnt_t'(`RESET_TICKS)) ? clk_pkg::rst_run
              : (c == 0) ? clk_pkg::rst_hold : clk_pkg::rst_count;
         check_state(got, want, "reset sequencer state");
         tally(seen, clk_3mhz_en);
         if (c <= `VSP_MULT) begin
            check_bit(vsp_clk_en, (c == 0) || (c == `VSP_MULT), "vsp_clk_en after release");
         end
      end
   endtask

   task automatic base_periods();
      clk_pkg::tick_cnt_t n_vdp, n_vga, n_sgc, n_tick, n_ovl;
      logic               p_vdp, p_vga, p_sgc, p_tick, p_ovl, p_next;
      int                 c;
      n_vdp  = '0;
      n_vga  = '0;
      n_sgc  = '0;
      n_tick = '0;
      n_ovl  = '0;
      p_vdp  = vdp_clk_en;
      p_vga  = vga_clk_en;
      p_sgc  = sgc_clk_en;
      p_tick = clk_3mhz_en;
      p_ovl  = overlay_clk_en;
      p_next = vdp_clk_en_next;
      for (c = 0; c < base_win; c++) begin
         next_cycle();
         check_bit(vdp_clk_en, p_next, "vdp_clk_en one cycle after vdp_clk_en_next");
         no_adjacent(p_vdp, vdp_clk_en, 2 * `VDP_MULT, "vdp_clk_en");
         no_adjacent(p_vga, vga_clk_en, `VDP_MULT, "vga_clk_en");
         no_adjacent(p_sgc, sgc_clk_en, 3 * `VDP_MULT, "sgc_clk_en");
         no_adjacent(p_tick, clk_3mhz_en, `CPU_MULT, "clk_3mhz_en");
         no_adjacent(p_ovl, overlay_clk_en, ovl_period, "overlay_clk_en");
         tally(n_vdp, vdp_clk_en);
         tally(n_vga, vga_clk_en);
         tally(n_sgc, sgc_clk_en);
         tally(n_tick, clk_3mhz_en);
         tally(n_ovl, overlay_clk_en);
         p_vdp  = vdp_clk_en;
         p_vga  = vga_clk_en;
         p_sgc  = sgc_clk_en;
         p_tick = clk_3mhz_en;
         p_ovl  = overlay_clk_en;
         p_next = vdp_clk_en_next;
      end
      check_count(n_vdp, clk_pkg::tick_cnt_t'(base_win / (2 * `VDP_MULT)), "vdp strobes");
      check_count(n_vga, clk_pkg::tick_cnt_t'(base_win / `VDP_MULT), "vga strobes");
      check_count(n_sgc, clk_pkg::tick_cnt_t'(base_win / (3 * `VDP_MULT)), "sgc strobes");
      check_count(n_tick, clk_pkg::tick_cnt_t'(base_win / `CPU_MULT), "3 MHz strobes");
      check_count(n_ovl, clk_pkg::tick_cnt_t'((`OVERLAY_EN != 0) ? base_win / ovl_period : 0),
                  "overlay strobes");
   endtask

   task automatic turbo_switching();
      int run;
      int len;
      int c;
      for (run = 0; run < turbo_runs; run++) begin
         len = 8 + int'(rand_bits(5));
         @(posedge clk);
         cpu_turbo <= (run % 2 == 0);    // On and off in turn
         for (c = 0; c < len; c++) begin
            next_cycle();
            check_bit(cpu_clk_en, turbo_last | clk_3mhz_en, "cpu_clk_en");
            check_bit(grom_clk_en, turbo_last | grom_due, "grom_clk_en");
         end
      end
   endtask

   task automatic vsp_spacing();
      clk_pkg::tick_cnt_t gap;
      clk_pkg::tick_cnt_t pulses;
      logic               armed;
      int                 c;
      gap    = '0;
      pulses = '0;
      armed  = 1'b0;
      for (c = 0; c < vsp_win; c++) begin
         if (c == 0 || c == vsp_win / 2) begin
            @(posedge clk);
            cpu_turbo <= (c == 0);       // Turbo in the first half only
         end
         next_cycle();
         gap++;
         if (vsp_clk_en) begin
            if (armed) begin
               check_count(gap, clk_pkg::tick_cnt_t'(`VSP_MULT), "cycles between vsp pulses");
            end
            armed = 1'b1;
            gap   = '0;
            pulses++;
         end
      end
      check_count(pulses, clk_pkg::tick_cnt_t'(vsp_win / `VSP_MULT), "vsp pulses in window");
   endtask

   initial begin
      ext_reset_in = 1'b1;
      cpu_turbo    = 1'b0;
      reset_length();                    // Power-up
      base_periods();
      turbo_switching();
      vsp_spacing();
      reset_length();                    // Reset while running
      $display("PASS: all tests");
      $finish;
   end

endmodule

/* flist.f */
+incdir+logic
+incdir+bench
logic/clk_pkg.sv
logic/clk_en_if.sv
logic/ring_dividers.sv
logic/derived_rates.sv
logic/reset_sequencer.sv
logic/clk_enables_top.sv
bench/tb_clk_enables.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

# Lint warnings are still printed but do not stop the build
verilator --binary --timing -Wno-fatal \
   --top-module tb_clk_enables \
   -f flist.f

# The run ends with $fatal on any failure, which gives a nonzero exit status
./obj_dir/Vtb_clk_enables
